//--- Bender.yml
package:
  name: mem_input_stage

sources:
  - files:
      - logic/memAccessPkg.sv
      - logic/tlbPkg.sv
      - logic/accessAligner.sv
      - logic/tlbLookup.sv
      - logic/creditIssue.sv
      - logic/memInputStage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/memInputStageTb.sv

export_include_dirs:
  - include

//--- files.f
+incdir+include
logic/memAccessPkg.sv
logic/tlbPkg.sv
logic/accessAligner.sv
logic/tlbLookup.sv
logic/creditIssue.sv
logic/memInputStage.sv
verification/memInputStageTb.sv

//--- logic/accessAligner.sv
`timescale 1ns/10ps

module accessAligner (
    input  logic [31:0]                       reqAddress,
    input  logic [1:0]                        reqSize,
    input  logic [63:0]                       reqData,
    output logic [31:0]                       line0Address,
    output logic [31:0]                       line1Address,
    output logic                              needSecond,
    output logic [memAccessPkg::LineBits-1:0] mask0,
    output logic [memAccessPkg::LineBits-1:0] mask1,
    output logic [memAccessPkg::LineBits-1:0] data0,
    output logic [memAccessPkg::LineBits-1:0] data1
);

    memAccessPkg::virtAddr_u addr;

    logic [3:0]   accessLen;
    logic [4:0]   endByte;
    logic [15:0]  lenBytes;
    logic [127:0] lenBits;
    logic [63:0]  storeData;
    logic [31:0]  laneBytes;
    logic [255:0] laneData;

    // widen each byte enable to eight mask bits
    function automatic logic [127:0] expandBytes(input logic [15:0] byteEn);
        logic [127:0] bits;
        for (int i = 0; i < 16; i++) begin
            bits[i*8 +: 8] = {8{byteEn[i]}};
        end
        return bits;
    endfunction

    assign addr = reqAddress;

    always_comb begin
        accessLen = 4'd1;
        case (reqSize)
            memAccessPkg::SizeByte:   accessLen = 4'd1;
            memAccessPkg::SizeHalf:   accessLen = 4'd2;
            memAccessPkg::SizeWord:   accessLen = 4'd4;
            memAccessPkg::SizeDouble: accessLen = 4'd8;
        endcase
    end

    // second line when the last byte runs past the line end
    assign endByte    = {1'b0, addr.line.byteInLine} + {1'b0, accessLen};
    assign needSecond = int'(endByte) > memAccessPkg::LineBytes;

    assign line0Address = reqAddress;
    assign line1Address = {addr.line.lineNum + 28'd1, 4'd0};

    // access bytes right-justified
    assign lenBytes  = (16'd1 << accessLen) - 16'd1;
    assign lenBits   = expandBytes(lenBytes);

    // upper store bytes beyond the size are don't care upstream
    assign storeData = reqData & lenBits[63:0];

    // shift across a double-line window with line 0 in the low half
    assign laneBytes = {16'd0, lenBytes} << addr.line.byteInLine;
    assign laneData  = {192'd0, storeData} << {addr.line.byteInLine, 3'b000};

    assign mask0 = expandBytes(laneBytes[15:0]);
    assign data0 = laneData[127:0];

    // bytes that spill into the next line
    assign mask1 = expandBytes(laneBytes[31:16]);
    assign data1 = laneData[255:128];

    // every access byte lands in exactly one line
    lengthKept: assert final (
        $isunknown({reqAddress, reqSize}) ||
        ($countones(mask0) + $countones(mask1) == 8 * accessLen)
    ) else $error("aligner masks cover %0d bits for a %0d-byte access",
                  $countones(mask0) + $countones(mask1), accessLen);

endmodule

//--- logic/creditIssue.sv
`timescale 1ns/10ps

module creditIssue (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              accept,
    input  logic                              fault,
    input  logic                              line0Valid,
    input  logic                              line1Valid,
    input  logic [memAccessPkg::PhysBits-1:0] phys0Address,
    input  logic [memAccessPkg::PhysBits-1:0] phys1Address,
    input  logic [memAccessPkg::LineBits-1:0] lineMask0,
    input  logic [memAccessPkg::LineBits-1:0] lineMask1,
    input  logic [memAccessPkg::LineBits-1:0] lineData0,
    input  logic [memAccessPkg::LineBits-1:0] lineData1,
    input  logic                              reqMiss,
    input  logic                              reqProtFault,
    input  logic                              reqUncached,
    input  logic                              creditReturn,
    output logic                              stageReady,
    output logic                              out0Valid,
    output logic [memAccessPkg::PhysBits-1:0] out0Address,
    output logic [memAccessPkg::LineBits-1:0] out0Data,
    output logic [memAccessPkg::LineBits-1:0] out0Mask,
    output logic                              out1Valid,
    output logic [memAccessPkg::PhysBits-1:0] out1Address,
    output logic [memAccessPkg::LineBits-1:0] out1Data,
    output logic [memAccessPkg::LineBits-1:0] out1Mask,
    output logic                              tlbMiss,
    output logic                              protFault,
    output logic                              uncached
);

    logic [memAccessPkg::CreditBits-1:0] creditCount;
    logic [1:0]                          spend;
    logic                                issue;

    assign issue = accept && !fault;
    assign spend = issue ? ({1'b0, line0Valid} + {1'b0, line1Valid}) : 2'd0;

    // two credits in hand so a split access always fits
    assign stageReady = creditCount >= 2;

    always_ff @(posedge clk) begin
        if (reset) begin
            creditCount <= memAccessPkg::CreditBits'(memAccessPkg::MaxCredits);
            out0Valid   <= 1'b0;
            out1Valid   <= 1'b0;
            tlbMiss     <= 1'b0;
            protFault   <= 1'b0;
            uncached    <= 1'b0;
        end else begin
            creditCount <= creditCount + {{(memAccessPkg::CreditBits - 1){1'b0}}, creditReturn}
                           - {{(memAccessPkg::CreditBits - 2){1'b0}}, spend};
            out0Valid   <= issue && line0Valid;
            out1Valid   <= issue && line1Valid;
            tlbMiss     <= accept && reqMiss;
            protFault   <= accept && reqProtFault;
            // flag rides along with the issued lines
            uncached    <= issue && reqUncached;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out0Address <= phys0Address;
            out0Mask    <= lineMask0;
            out0Data    <= lineData0;
            out1Address <= phys1Address;
            out1Mask    <= lineMask1;
            out1Data    <= lineData1;
        end
    end

    // cache returns no more slots than it was given
    creditCeiling: assert property (@(posedge clk) disable iff (reset)
        creditCount <= memAccessPkg::MaxCredits
    ) else $error("credit count %0d above the cache depth", creditCount);

    creditFloor: assert property (@(posedge clk) disable iff (reset)
        (spend != 2'd0) |-> (creditCount >= spend)
    ) else $error("issue spends %0d credits with %0d left", spend, creditCount);

endmodule

//--- logic/memAccessPkg.sv
package memAccessPkg;

    // cache line geometry
    localparam int LineBytes = 16;
    localparam int LineBits  = 128;

    // frame bits plus the 12-bit page offset
    localparam int PhysBits = 15;

    // request slots the cache can hold at once
    localparam int MaxCredits = 4;
    localparam int CreditBits = $clog2(MaxCredits + 1);

    // access size codes
    localparam logic [1:0] SizeByte   = 2'b00;
    localparam logic [1:0] SizeHalf   = 2'b01;
    localparam logic [1:0] SizeWord   = 2'b10;
    localparam logic [1:0] SizeDouble = 2'b11;

    // page view for the TLB, line view for the aligner
    typedef union packed {
        struct packed {
            logic [19:0] pageNum;
            logic [11:0] pageOffset;
        } page;
        struct packed {
            logic [27:0] lineNum;
            logic [3:0]  byteInLine;
        } line;
    } virtAddr_u;

endpackage

//--- logic/memInputStage.sv
`timescale 1ns/10ps

module memInputStage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              reqValid,
    input  logic [31:0]                       reqAddress,
    input  logic [1:0]                        reqSize,
    input  logic                              reqWrite,
    input  logic [63:0]                       reqData,
    output logic                              stageReady,
    input  logic                              fillValid,
    input  logic [tlbPkg::TlbIndexBits-1:0]   fillIndex,
    input  logic [tlbPkg::VpnBits-1:0]        fillVpn,
    input  logic [tlbPkg::FrameBits-1:0]      fillFrame,
    input  logic                              fillWritable,
    input  logic                              fillUncached,
    input  logic                              creditReturn,
    output logic                              out0Valid,
    output logic [memAccessPkg::PhysBits-1:0] out0Address,
    output logic [memAccessPkg::LineBits-1:0] out0Data,
    output logic [memAccessPkg::LineBits-1:0] out0Mask,
    output logic                              out1Valid,
    output logic [memAccessPkg::PhysBits-1:0] out1Address,
    output logic [memAccessPkg::LineBits-1:0] out1Data,
    output logic [memAccessPkg::LineBits-1:0] out1Mask,
    output logic                              tlbMiss,
    output logic                              protFault,
    output logic                              uncached
);

    memAccessPkg::virtAddr_u             vAddr0;
    memAccessPkg::virtAddr_u             vAddr1;
    logic [31:0]                         line0Address;
    logic [31:0]                         line1Address;
    logic                                needSecond;
    logic [memAccessPkg::LineBits-1:0]   mask0;
    logic [memAccessPkg::LineBits-1:0]   mask1;
    logic [memAccessPkg::LineBits-1:0]   data0;
    logic [memAccessPkg::LineBits-1:0]   data1;
    logic [tlbPkg::FrameBits-1:0]        frame0;
    logic [tlbPkg::FrameBits-1:0]        frame1;
    logic                                miss0;
    logic                                miss1;
    logic                                prot0;
    logic                                prot1;
    logic                                uncached0;
    logic                                uncached1;
    logic                                anyMiss;
    logic                                anyProt;
    logic                                anyUncached;
    logic                                accept;

    accessAligner aligner (
        .reqAddress(reqAddress), .reqSize(reqSize), .reqData(reqData),
        .line0Address(line0Address), .line1Address(line1Address),
        .needSecond(needSecond), .mask0(mask0), .mask1(mask1),
        .data0(data0), .data1(data1)
    );

    assign vAddr0 = line0Address;
    assign vAddr1 = line1Address;

    // both copies see the same fills
    tlbLookup tlbLine0 (
        .clk(clk), .reset(reset), .fillValid(fillValid), .fillIndex(fillIndex),
        .fillVpn(fillVpn), .fillFrame(fillFrame), .fillWritable(fillWritable),
        .fillUncached(fillUncached), .lookupValid(reqValid),
        .lookupVpn(vAddr0.page.pageNum), .write(reqWrite), .frame(frame0),
        .hit(), .miss(miss0), .protFault(prot0), .uncached(uncached0)
    );

    tlbLookup tlbLine1 (
        .clk(clk), .reset(reset), .fillValid(fillValid), .fillIndex(fillIndex),
        .fillVpn(fillVpn), .fillFrame(fillFrame), .fillWritable(fillWritable),
        .fillUncached(fillUncached), .lookupValid(reqValid),
        .lookupVpn(vAddr1.page.pageNum), .write(reqWrite), .frame(frame1),
        .hit(), .miss(miss1), .protFault(prot1), .uncached(uncached1)
    );

    // second line only counts when the access crosses
    assign anyMiss     = miss0 || (needSecond && miss1);
    assign anyProt     = prot0 || (needSecond && prot1);
    assign anyUncached = uncached0 || (needSecond && uncached1);
    assign accept      = reqValid && stageReady;

    creditIssue issue (
        .clk(clk), .reset(reset), .accept(accept), .fault(anyMiss || anyProt),
        .line0Valid(reqValid), .line1Valid(reqValid && needSecond),
        .phys0Address({frame0, vAddr0.page.pageOffset}),
        .phys1Address({frame1, vAddr1.page.pageOffset}),
        .lineMask0(mask0), .lineMask1(mask1), .lineData0(data0), .lineData1(data1),
        .reqMiss(anyMiss), .reqProtFault(anyProt), .reqUncached(anyUncached),
        .creditReturn(creditReturn), .stageReady(stageReady),
        .out0Valid(out0Valid), .out0Address(out0Address), .out0Data(out0Data),
        .out0Mask(out0Mask), .out1Valid(out1Valid), .out1Address(out1Address),
        .out1Data(out1Data), .out1Mask(out1Mask), .tlbMiss(tlbMiss),
        .protFault(protFault), .uncached(uncached)
    );

endmodule

//--- logic/tlbLookup.sv
`timescale 1ns/10ps

module tlbLookup (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            fillValid,
    input  logic [tlbPkg::TlbIndexBits-1:0] fillIndex,
    input  logic [tlbPkg::VpnBits-1:0]      fillVpn,
    input  logic [tlbPkg::FrameBits-1:0]    fillFrame,
    input  logic                            fillWritable,
    input  logic                            fillUncached,
    input  logic                            lookupValid,
    input  logic [tlbPkg::VpnBits-1:0]      lookupVpn,
    input  logic                            write,
    output logic [tlbPkg::FrameBits-1:0]    frame,
    output logic                            hit,
    output logic                            miss,
    output logic                            protFault,
    output logic                            uncached
);

    logic [tlbPkg::TlbEntries-1:0] entryValid;
    logic [tlbPkg::TlbEntries-1:0] entryWritable;
    logic [tlbPkg::TlbEntries-1:0] entryUncached;
    logic [tlbPkg::VpnBits-1:0]    entryVpn [tlbPkg::TlbEntries];
    logic [tlbPkg::FrameBits-1:0]  entryFrame [tlbPkg::TlbEntries];
    logic [tlbPkg::TlbEntries-1:0] match;
    logic                          selWritable;
    logic                          selUncached;

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (fillValid) begin
            entryValid[fillIndex] <= 1'b1;
        end
    end

    // entry payload, written by the fill port
    always_ff @(posedge clk) begin
        if (fillValid) begin
            entryVpn[fillIndex]      <= fillVpn;
            entryFrame[fillIndex]    <= fillFrame;
            entryWritable[fillIndex] <= fillWritable;
            entryUncached[fillIndex] <= fillUncached;
        end
    end

    // parallel compare, match is one-hot so an OR selects
    always_comb begin
        frame       = '0;
        selWritable = 1'b0;
        selUncached = 1'b0;
        for (int i = 0; i < tlbPkg::TlbEntries; i++) begin
            match[i] = entryValid[i] && (entryVpn[i] == lookupVpn);
            if (match[i]) begin
                frame       = frame | entryFrame[i];
                selWritable = selWritable | entryWritable[i];
                selUncached = selUncached | entryUncached[i];
            end
        end
    end

    assign hit       = lookupValid && (|match);
    assign miss      = lookupValid && !(|match);
    assign protFault = hit && write && !selWritable;
    assign uncached  = hit && selUncached;

    // fill software must not map one page twice
    uniqueMatch: assert property (@(posedge clk) disable iff (reset)
        lookupValid |-> $onehot0(match)
    ) else $error("TLB has several valid entries for page %h", lookupVpn);

endmodule

//--- logic/tlbPkg.sv
package tlbPkg;

    // fully associative, filled through the fill port
    localparam int TlbEntries = 8;

    // entry index width, log2 of the entry count
    localparam int TlbIndexBits = 3;

    // 4 KiB pages on a 32-bit virtual address
    localparam int VpnBits = 20;

    // physical frame number
    // with the page offset this gives a 15-bit physical address
    localparam int FrameBits = 3;

endpackage

//--- include/stageVectors.svh
`ifndef STAGE_VECTORS_SVH
`define STAGE_VECTORS_SVH

// expected outcome of each access
localparam int FaultNone     = 0;
localparam int FaultMiss     = 1;
localparam int FaultProt     = 2;
localparam int FaultUncached = 3;

localparam int NumTests = 14;

localparam string TestName [NumTests] = '{
    "byteAligned", "halfAligned", "wordAligned", "doubleAligned", "doubleSplit",
    "wordSplit", "missPage", "missSecond", "protWrite", "protRead",
    "uncachedRead", "creditFault", "creditSplit", "creditSingle"
};

// page 3 read-only, page 5 uncacheable, page 6 unmapped
localparam logic [31:0] TestAddress [NumTests] = '{
    32'h0000_0010, 32'h0000_1022, 32'h0000_2044, 32'h0000_4088, 32'h0000_100D,
    32'h0000_203E, 32'h0000_6000, 32'h0000_5FFC, 32'h0000_3010, 32'h0000_3010,
    32'h0000_5020, 32'h0000_6100, 32'h0000_402D, 32'h0000_0130
};

localparam logic [1:0] TestSize [NumTests] = '{
    2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd2, 2'd0, 2'd3, 2'd2, 2'd2, 2'd1, 2'd2, 2'd2, 2'd0
};

localparam logic TestWrite [NumTests] = '{
    1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1
};

localparam int TestFault [NumTests] = '{
    FaultNone, FaultNone, FaultNone, FaultNone, FaultNone, FaultNone, FaultMiss,
    FaultMiss, FaultProt, FaultNone, FaultUncached, FaultMiss, FaultNone, FaultNone
};

// withheld returns let the credit count run down
localparam logic TestHold [NumTests] = '{
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1
};

`endif

//--- verification/memInputStageTb.sv
`timescale 1ns/10ps

module memInputStageTb;

    `include "stageVectors.svh"

    localparam int ClkPeriod      = 40;
    localparam int ResetCycles    = 8;
    localparam int WatchdogCycles = NumTests * 20 + ResetCycles;

    logic         clk;
    logic         reset;
    logic         reqValid;
    logic [31:0]  reqAddress;
    logic [1:0]   reqSize;
    logic         reqWrite;
    logic [63:0]  reqData;
    logic         stageReady;
    logic         fillValid;
    logic [2:0]   fillIndex;
    logic [19:0]  fillVpn;
    logic [2:0]   fillFrame;
    logic         fillWritable;
    logic         fillUncached;
    logic         creditReturn;
    logic         out0Valid;
    logic [14:0]  out0Address;
    logic [127:0] out0Data;
    logic [127:0] out0Mask;
    logic         out1Valid;
    logic [14:0]  out1Address;
    logic [127:0] out1Data;
    logic [127:0] out1Mask;
    logic         tlbMiss;
    logic         protFault;
    logic         uncached;

    logic [15:0]  lfsrState;
    int           errors;
    int           testsFailed;
    int           expCredits;
    logic [127:0] expMask0;
    logic [127:0] expMask1;
    logic [127:0] expData0;
    logic [127:0] expData1;
    logic [14:0]  expAddr0;
    logic [14:0]  expAddr1;
    logic         expSplit;

    memInputStage i_dut (
        .clk(clk), .reset(reset), .reqValid(reqValid), .reqAddress(reqAddress),
        .reqSize(reqSize), .reqWrite(reqWrite), .reqData(reqData), .stageReady(stageReady),
        .fillValid(fillValid), .fillIndex(fillIndex), .fillVpn(fillVpn),
        .fillFrame(fillFrame), .fillWritable(fillWritable), .fillUncached(fillUncached),
        .creditReturn(creditReturn), .out0Valid(out0Valid), .out0Address(out0Address),
        .out0Data(out0Data), .out0Mask(out0Mask), .out1Valid(out1Valid),
        .out1Address(out1Address), .out1Data(out1Data), .out1Mask(out1Mask),
        .tlbMiss(tlbMiss), .protFault(protFault), .uncached(uncached)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic nextData(output logic [63:0] d);
        for (int i = 0; i < 64; i++) begin
            lfsrState = lfsrStep(lfsrState);
            d[i] = lfsrState[0];
        end
    endtask

    // fill mapping used below, page p sits in frame p+1
    function automatic logic [2:0] frameOf(input logic [19:0] page);
        return 3'(page + 20'd1);
    endfunction

    // byte by byte placement, spill bytes start over at byte 0 of the next line
    task automatic buildExpected(input logic [31:0] addr, input logic [1:0] size,
                                 input logic [63:0] data);
        int len;
        int pos;
        logic [31:0] nextLine;
        len = 1 << size;
        expMask0 = '0;
        expMask1 = '0;
        expData0 = '0;
        expData1 = '0;
        for (int i = 0; i < len; i++) begin
            pos = int'(addr[3:0]) + i;
            if (pos < 16) begin
                expMask0[pos*8 +: 8] = 8'hFF;
                expData0[pos*8 +: 8] = data[i*8 +: 8];
            end else begin
                expMask1[(pos-16)*8 +: 8] = 8'hFF;
                expData1[(pos-16)*8 +: 8] = data[i*8 +: 8];
            end
        end
        expSplit = (int'(addr[3:0]) + len) > 16;
        nextLine = {addr[31:4] + 28'd1, 4'd0};
        expAddr0 = {frameOf(addr[31:12]), addr[11:0]};
        expAddr1 = {frameOf(nextLine[31:12]), nextLine[11:0]};
    endtask

    task automatic checkValue(input string name, input string field,
                              input logic [127:0] expected, input logic [127:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    // one pulse per freed slot
    task automatic returnCredits(input int n);
        repeat (n) begin
            creditReturn = 1'b1;
            @(negedge clk);
        end
        creditReturn = 1'b0;
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, run did not complete", WatchdogCycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int  startErrors;
        int  spent;
        logic expIssue;
        logic [63:0] storeData;
        reset        = 1'b1;
        reqValid     = 1'b0;
        reqAddress   = '0;
        reqSize      = '0;
        reqWrite     = 1'b0;
        reqData      = '0;
        fillValid    = 1'b0;
        fillIndex    = '0;
        fillVpn      = '0;
        fillFrame    = '0;
        fillWritable = 1'b0;
        fillUncached = 1'b0;
        creditReturn = 1'b0;
        lfsrState    = 16'd10880;
        errors       = 0;
        testsFailed  = 0;
        expCredits   = memAccessPkg::MaxCredits;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // pages 0 to 5 mapped, 3 read-only, 5 uncacheable
        for (int p = 0; p < 6; p++) begin
            fillValid    = 1'b1;
            fillIndex    = 3'(p);
            fillVpn      = 20'(p);
            fillFrame    = frameOf(20'(p));
            fillWritable = (p != 3);
            fillUncached = (p == 5);
            @(negedge clk);
        end
        fillValid = 1'b0;

        for (int t = 0; t < NumTests; t++) begin
            startErrors = errors;
            nextData(storeData);
            buildExpected(TestAddress[t], TestSize[t], storeData);
            expIssue = (TestFault[t] != FaultMiss) && (TestFault[t] != FaultProt);
            checkValue(TestName[t], "stageReady", 128'(expCredits >= 2), 128'(stageReady));
            if (stageReady) begin
                reqValid   = 1'b1;
                reqAddress = TestAddress[t];
                reqSize    = TestSize[t];
                reqWrite   = TestWrite[t];
                reqData    = storeData;
                @(negedge clk);
                reqValid = 1'b0;
                checkValue(TestName[t], "out0Valid", 128'(expIssue), 128'(out0Valid));
                checkValue(TestName[t], "out1Valid", 128'(expIssue && expSplit), 128'(out1Valid));
                checkValue(TestName[t], "tlbMiss", 128'(TestFault[t] == FaultMiss), 128'(tlbMiss));
                checkValue(TestName[t], "protFault", 128'(TestFault[t] == FaultProt),
                           128'(protFault));
                checkValue(TestName[t], "uncached", 128'(TestFault[t] == FaultUncached),
                           128'(uncached));
                if (expIssue) begin
                    checkValue(TestName[t], "out0Address", 128'(expAddr0), 128'(out0Address));
                    checkValue(TestName[t], "out0Mask", expMask0, out0Mask);
                    checkValue(TestName[t], "out0Data", expData0, out0Data);
                end
                if (expIssue && expSplit) begin
                    checkValue(TestName[t], "out1Address", 128'(expAddr1), 128'(out1Address));
                    checkValue(TestName[t], "out1Mask", expMask1, out1Mask);
                    checkValue(TestName[t], "out1Data", expData1, out1Data);
                end
                spent      = expIssue ? (expSplit ? 2 : 1) : 0;
                expCredits = expCredits - spent;
                if (!TestHold[t]) begin
                    returnCredits(spent);
                    expCredits = expCredits + spent;
                end
            end else begin
                errors++;
                $display("%s: stage not ready when the request was due, request skipped",
                         TestName[t]);
            end
            if (errors == startErrors) begin
                $display("test %-14s ok", TestName[t]);
            end else begin
                testsFailed++;
                $display("test %-14s %0d error(s)", TestName[t], errors - startErrors);
            end
        end

        // held returns leave one credit, one pulse brings ready back
        startErrors = errors;
        checkValue("creditRecover", "stageReady", 128'(expCredits >= 2), 128'(stageReady));
        returnCredits(1);
        expCredits++;
        checkValue("creditRecover", "stageReady", 128'(expCredits >= 2), 128'(stageReady));
        returnCredits(memAccessPkg::MaxCredits - expCredits);
        if (errors == startErrors) begin
            $display("test %-14s ok", "creditRecover");
        end else begin
            testsFailed++;
            $display("test %-14s %0d error(s)", "creditRecover", errors - startErrors);
        end

        $display("tests %0d, failed %0d, check errors %0d", NumTests + 1, testsFailed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
